//--- corr_pkg.sv
package corr_pkg;

   // ----------------------------------------------------------
   // Array and bus dimensions
   // ----------------------------------------------------------
   localparam int NANT      = 4;  // Antennas, one bit each
   localparam int NPAIR_BLK = 3;  // Baselines per correlator block
   localparam int ADDR_BITS = 5;  // Bus word address
   localparam int DATA_BITS = 16; // Bus data word

   // Antenna pair of one baseline
   typedef struct packed {
      logic [1:0] a;              // First antenna, real part only
      logic [1:0] b;              // Second antenna, real or imaginary
   } pair_t;

   // Block 0 owns entries 0..2, block 1 owns entries 3..5
   localparam pair_t PAIR_TABLE [6] = '{
      '{2'd0, 2'd1},
      '{2'd0, 2'd2},
      '{2'd0, 2'd3},
      '{2'd1, 2'd2},
      '{2'd1, 2'd3},
      '{2'd2, 2'd3}
   };

   // Unit select, taken from address bits 4:3 (value 3 maps to nothing)
   typedef enum logic [1:0] {
      UNIT_BLK0 = 2'd0,
      UNIT_BLK1 = 2'd1,
      UNIT_SYS  = 2'd2
   } unit_e;

   // ----------------------------------------------------------
   // Register bus, single master
   // ----------------------------------------------------------
   typedef struct packed {
      logic                 cyc;
      logic                 stb;  // One cycle per access
      logic                 we;
      logic [ADDR_BITS-1:0] adr;
      logic [DATA_BITS-1:0] dat;
   } bus_req_t;

   typedef struct packed {
      logic                 ack;  // Two cycles after the strobe
      logic [DATA_BITS-1:0] dat;  // Held until the next read ack
   } bus_rsp_t;

   // Hilbert stage output
   typedef struct packed {
      logic [NANT-1:0] re;
      logic [NANT-1:0] im;        // Quadrature estimate
   } samp_t;

endpackage

//--- hilbert_delay.sv
module hilbert_delay (
   input  logic                      clk_i,
   input  logic                      sw_d,      // Async reset, active high
   input  logic                      strobe_i,  // antenna_i is valid
   input  logic                      enable_i,  // Acquisition enabled
   input  logic [corr_pkg::NANT-1:0] antenna_i, // Real bit of each antenna
   output corr_pkg::samp_t           samp_o,
   output logic                      go_o       // One pulse per valid sample
);

   logic                      accept;           // Sample taken this cycle
   logic                      active;           // Previous sample exists
   logic [corr_pkg::NANT-1:0] prev;             // Last accepted sample

   assign accept = strobe_i && enable_i;

   // Control state
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         active <= 1'b0;
         go_o   <= 1'b0;
      end else begin
         go_o <= accept;                        // Sample lands in samp_o with go
         if (!enable_i)     active <= 1'b0;     // History dropped on disable
         else if (strobe_i) active <= 1'b1;
      end
   end

   // Sample path
   // Stand-in quadrature: the antenna's previous sample, zero when none
   always_ff @(posedge clk_i) begin
      if (accept) begin
         samp_o.re <= antenna_i;
         samp_o.im <= active ? prev : '0;
         prev      <= antenna_i;
      end
   end

endmodule

//--- bank_control.sv
module bank_control #(
   parameter int ACCUM_BITS = 16              // Width of the block counter
) (
   input  logic                           clk_i,
   input  logic                           sw_d,        // Async reset
   input  logic                           go_i,        // Valid sample pulse
   input  logic [corr_pkg::DATA_BITS-1:0] blocksize_i, // Samples per block - 1
   output logic                           swap_o,      // Freeze counts now
   output logic                           switch_o     // Bank switched
);

   // ----------------------------------------------------------
   // Block sample counter
   // ----------------------------------------------------------
   logic [ACCUM_BITS-1:0] blk_cnt;             // Samples so far in block
   logic [ACCUM_BITS-1:0] blk_last;            // Index of the last sample
   logic                  wrap;

   // A block longer than the counters can hold would overflow anyway
   assign blk_last = ACCUM_BITS'(blocksize_i);
   assign wrap     = (blk_cnt == blk_last);

   // Swap on the go that completes the block, same cycle
   assign swap_o = go_i && wrap;

   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         blk_cnt <= '0;
      end else if (go_i) begin
         // Only reset restarts it, so blocks stay sample-aligned
         blk_cnt <= wrap ? '0 : blk_cnt + 1'b1;
      end
   end

   // ----------------------------------------------------------
   // Switch pulse, one cycle behind swap
   // ----------------------------------------------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) switch_o <= 1'b0;
      else      switch_o <= swap_o;
   end

endmodule

//--- correlator_block.sv
module correlator_block #(
   parameter int ACCUM_BITS = 16,             // Counter width
   parameter int BASE       = 0               // First entry in PAIR_TABLE
) (
   input  logic                           clk_i,
   input  logic                           sw_d,     // Async reset
   input  logic                           go_i,     // Valid sample
   input  corr_pkg::samp_t                samp_i,
   input  logic                           swap_i,   // Freeze and restart
   input  logic                           stb_i,    // Unit selected for read
   input  logic [2:0]                     word_i,   // {pair, sin/cos}
   output logic [corr_pkg::DATA_BITS-1:0] rd_dat_o
);

   localparam int NP = corr_pkg::NPAIR_BLK;
   localparam int DW = corr_pkg::DATA_BITS;

   // Working and frozen banks
   logic [ACCUM_BITS-1:0] cos_w [NP];
   logic [ACCUM_BITS-1:0] sin_w [NP];
   logic [ACCUM_BITS-1:0] cos_f [NP];
   logic [ACCUM_BITS-1:0] sin_f [NP];
   logic [ACCUM_BITS-1:0] rd_word;             // Selected frozen count
   logic [1:0]            rd_pair;

   // ----------------------------------------------------------
   // One cosine and one sine counter per baseline
   // ----------------------------------------------------------
   for (genvar p = 0; p < NP; p++) begin : g_pair
      localparam corr_pkg::pair_t PR = corr_pkg::PAIR_TABLE[BASE+p];

      logic                  agree_c;           // re(a) == re(b)
      logic                  agree_s;           // re(a) == im(b)
      logic [ACCUM_BITS-1:0] inc_c;
      logic [ACCUM_BITS-1:0] inc_s;

      assign agree_c = samp_i.re[PR.a] ~^ samp_i.re[PR.b];
      assign agree_s = samp_i.re[PR.a] ~^ samp_i.im[PR.b];
      assign inc_c   = ACCUM_BITS'(go_i && agree_c);
      assign inc_s   = ACCUM_BITS'(go_i && agree_s);

      always_ff @(posedge clk_i or posedge sw_d) begin
         if (sw_d) begin
            cos_w[p] <= '0;
            sin_w[p] <= '0;
            cos_f[p] <= '0;                     // Frozen bank reads zero
            sin_f[p] <= '0;
         end else if (swap_i) begin
            cos_f[p] <= cos_w[p] + inc_c;       // Include the completing sample
            sin_f[p] <= sin_w[p] + inc_s;
            cos_w[p] <= '0;
            sin_w[p] <= '0;
         end else begin
            cos_w[p] <= cos_w[p] + inc_c;
            sin_w[p] <= sin_w[p] + inc_s;
         end
      end
   end

   // ----------------------------------------------------------
   // Word readout from the frozen bank
   // ----------------------------------------------------------
   assign rd_pair = word_i[2:1];

   always_comb begin
      rd_word = '0;                             // Words 6 and 7, or unselected
      if (stb_i && (rd_pair < NP)) begin
         if (word_i[0]) rd_word = sin_f[rd_pair];
         else           rd_word = cos_f[rd_pair];
      end
   end

   assign rd_dat_o = DW'(rd_word);              // Zero-extend or truncate

endmodule

//--- visibility_bus.sv
module visibility_bus (
   input  logic                           clk_i,
   input  logic                           sw_d,        // Async reset
   input  corr_pkg::bus_req_t             bus_req_i,
   input  logic                           swap_i,      // Block completed
   input  logic [corr_pkg::DATA_BITS-1:0] rd_dat0_i,   // From block 0
   input  logic [corr_pkg::DATA_BITS-1:0] rd_dat1_i,   // From block 1
   output corr_pkg::bus_rsp_t             bus_rsp_o,
   output logic [1:0]                     blk_stb_o,   // One-hot block strobes
   output logic [2:0]                     word_o,      // Word within unit
   output logic                           enable_o,
   output logic [corr_pkg::DATA_BITS-1:0] blocksize_o  // Block size - 1
);

   localparam int DW = corr_pkg::DATA_BITS;

   typedef enum logic [1:0] {BUS_IDLE, BUS_READ, BUS_WRITE} bus_state_e;

   bus_state_e      state;
   corr_pkg::unit_e unit_q;                    // Decoded on the strobe
   logic [DW-1:0]   wdat_q;
   logic [DW-1:0]   nblocks;                   // Completed blocks
   logic [DW-1:0]   sys_dat;
   logic [DW-1:0]   rd_mux;
   logic            req;

   assign req = bus_req_i.cyc && bus_req_i.stb;

   // ----------------------------------------------------------
   // Decode stage, registered on the strobe
   // ----------------------------------------------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         state     <= BUS_IDLE;
         unit_q    <= corr_pkg::UNIT_BLK0;
         word_o    <= '0;
         wdat_q    <= '0;
         blk_stb_o <= '0;
      end else begin
         blk_stb_o <= '0;
         if (state == BUS_IDLE && req) begin
            state     <= bus_req_i.we ? BUS_WRITE : BUS_READ;
            unit_q    <= corr_pkg::unit_e'(bus_req_i.adr[4:3]);
            word_o    <= bus_req_i.adr[2:0];
            wdat_q    <= bus_req_i.dat;
            blk_stb_o <= 2'b01 << bus_req_i.adr[3] & {2{!bus_req_i.adr[4]}};
         end else begin
            state <= BUS_IDLE;                  // Access takes one cycle here
         end
      end
   end

   // System register read side
   always_comb begin
      case (word_o)
         3'd0:    sys_dat = blocksize_o;
         3'd1:    sys_dat = DW'(enable_o);
         3'd2:    sys_dat = nblocks;
         default: sys_dat = '0;
      endcase
   end

   // Read data select
   always_comb begin
      case (unit_q)
         corr_pkg::UNIT_BLK0: rd_mux = rd_dat0_i;
         corr_pkg::UNIT_BLK1: rd_mux = rd_dat1_i;
         corr_pkg::UNIT_SYS:  rd_mux = sys_dat;
         default:             rd_mux = '0;      // Unit 3 unmapped
      endcase
   end

   // ----------------------------------------------------------
   // Response stage and system registers
   // ----------------------------------------------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         bus_rsp_o   <= '0;
         enable_o    <= 1'b0;
         blocksize_o <= DW'(3);
         nblocks     <= '0;
      end else begin
         bus_rsp_o.ack <= (state != BUS_IDLE);
         if (state == BUS_READ) bus_rsp_o.dat <= rd_mux;   // Held otherwise
         if (state == BUS_WRITE && unit_q == corr_pkg::UNIT_SYS) begin
            if (word_o == 3'd0) blocksize_o <= wdat_q;
            if (word_o == 3'd1) enable_o    <= wdat_q[0];
         end
         if (swap_i) nblocks <= nblocks + 1'b1; // Wraps at 16 bits
      end
   end

endmodule

//--- corr_top.sv
module corr_top #(
   parameter int ACCUM_BITS = 16              // Visibility counter width
) (
   input  logic                      clk_i,
   input  logic                      sw_d,      // Async reset, active high
   input  corr_pkg::bus_req_t        bus_req_i,
   input  logic                      strobe_i,
   input  logic [corr_pkg::NANT-1:0] antenna_i,
   output corr_pkg::bus_rsp_t        bus_rsp_o,
   output logic                      switch_o   // Pulses after each block
);

   // ----------------------------------------------------------
   // Internal nets
   // ----------------------------------------------------------
   corr_pkg::samp_t                samp;
   logic                           go;
   logic                           swap;
   logic                           enable;
   logic [corr_pkg::DATA_BITS-1:0] blocksize;
   logic [1:0]                     blk_stb;
   logic [2:0]                     word;
   logic [corr_pkg::DATA_BITS-1:0] rd_dat0;
   logic [corr_pkg::DATA_BITS-1:0] rd_dat1;

   // Quadrature estimate and sample pulse
   hilbert_delay u_hilb (
      .clk_i     (clk_i),
      .sw_d      (sw_d),
      .strobe_i  (strobe_i),
      .enable_i  (enable),
      .antenna_i (antenna_i),
      .samp_o    (samp),
      .go_o      (go)
   );

   bank_control #(.ACCUM_BITS(ACCUM_BITS)) u_bank (
      .clk_i       (clk_i),
      .sw_d        (sw_d),
      .go_i        (go),
      .blocksize_i (blocksize),
      .swap_o      (swap),
      .switch_o    (switch_o)
   );

   // Baselines (0,1) (0,2) (0,3)
   correlator_block #(.ACCUM_BITS(ACCUM_BITS), .BASE(0)) u_blk0 (
      .clk_i    (clk_i),
      .sw_d     (sw_d),
      .go_i     (go),
      .samp_i   (samp),
      .swap_i   (swap),
      .stb_i    (blk_stb[0]),
      .word_i   (word),
      .rd_dat_o (rd_dat0)
   );

   // Baselines (1,2) (1,3) (2,3)
   correlator_block #(.ACCUM_BITS(ACCUM_BITS), .BASE(3)) u_blk1 (
      .clk_i    (clk_i),
      .sw_d     (sw_d),
      .go_i     (go),
      .samp_i   (samp),
      .swap_i   (swap),
      .stb_i    (blk_stb[1]),
      .word_i   (word),
      .rd_dat_o (rd_dat1)
   );

   visibility_bus u_bus (
      .clk_i       (clk_i),
      .sw_d        (sw_d),
      .bus_req_i   (bus_req_i),
      .swap_i      (swap),
      .rd_dat0_i   (rd_dat0),
      .rd_dat1_i   (rd_dat1),
      .bus_rsp_o   (bus_rsp_o),
      .blk_stb_o   (blk_stb),
      .word_o      (word),
      .enable_o    (enable),
      .blocksize_o (blocksize)
   );

endmodule

//--- corr_checker.sv
module corr_checker (
   input logic               clk_i,
   input logic               sw_d,
   input logic               req_i,     // Bus strobe cycle
   input corr_pkg::bus_rsp_t rsp_i,
   input logic               swap_i,    // Bank control freeze pulse
   input logic               go_i,
   input logic               switch_i
);

   timeunit 1ns;
   timeprecision 100ps;

   int fail_cnt = 0;                    // Read by the testbench at the end

   // ----------------------------------------------------------
   // Bus handshake
   // ----------------------------------------------------------
   ack_single : assert property (@(posedge clk_i) disable iff (sw_d)
      rsp_i.ack |=> !rsp_i.ack)
      else begin
         fail_cnt++;
         $error("ack high for two cycles");
      end

   ack_latency : assert property (@(posedge clk_i) disable iff (sw_d)
      req_i |-> ##2 rsp_i.ack)          // Two cycles after the strobe
      else begin
         fail_cnt++;
         $error("ack missing two cycles after strobe");
      end

   // ----------------------------------------------------------
   // Bank switching
   // ----------------------------------------------------------
   switch_after_swap : assert property (@(posedge clk_i) disable iff (sw_d)
      swap_i |=> switch_i)
      else begin
         fail_cnt++;
         $error("switch_o did not follow swap");
      end

   switch_needs_swap : assert property (@(posedge clk_i) disable iff (sw_d)
      switch_i |-> $past(swap_i))
      else begin
         fail_cnt++;
         $error("switch_o without swap");
      end

   // Outputs quiet while in reset
   reset_quiet : assert property (@(posedge clk_i)
      sw_d |-> !rsp_i.ack && rsp_i.dat == '0 && !swap_i && !go_i && !switch_i)
      else begin
         fail_cnt++;
         $error("output active during reset");
      end

endmodule

bind corr_top corr_checker u_chk (
   .clk_i    (clk_i),
   .sw_d     (sw_d),
   .req_i    (bus_req_i.cyc && bus_req_i.stb),
   .rsp_i    (bus_rsp_o),
   .swap_i   (swap),
   .go_i     (go),
   .switch_i (switch_o)
);

//--- tb_monitor.sv
module tb_monitor (
   input  logic               clk_i,
   input  logic               sw_d,
   input  logic               strobe_i,
   input  logic [3:0]         antenna_i,
   input  corr_pkg::bus_req_t bus_req_i,
   input  corr_pkg::bus_rsp_t bus_rsp_i,
   input  logic               switch_i,
   input  logic [7:0]         test_i,    // 0 closes the run
   input  logic               lit_en_i,  // Extra check against a fixed value
   input  logic [15:0]        lit_val_i,
   output int                 err_cnt_o
);

   timeunit 1ns;
   timeprecision 100ps;

   // Baselines (first antenna, second antenna), unit 0 then unit 1
   localparam int PA [6] = '{0, 0, 0, 1, 1, 2};
   localparam int PB [6] = '{1, 2, 3, 2, 3, 3};

   int          cos_w [6];             // Working counts
   int          sin_w [6];
   int          cos_p [6];             // Completed block, not yet switched
   int          sin_p [6];
   int          cos_f [6];             // Frozen, what the bus reads
   int          sin_f [6];
   logic [3:0]  prev;
   bit          active;
   bit          en;
   bit          pend;
   bit          rd_wait;
   bit          lit_q;                 // Literal wanted for the read in flight
   logic [15:0] lit_val_q;
   int          bs;
   int          cnt;
   int          nblk;
   int          errs;
   int          test_errs;
   int          tests_ok;
   int          tests_bad;
   int          cur_test;
   logic [4:0]  rd_adr;

   assign err_cnt_o = errs;

   // Quadrature rule and agreement counting for one accepted sample
   task automatic take_sample(input logic [3:0] re);
      logic [3:0] im;
      im = active ? prev : 4'h0;
      for (int k = 0; k < 6; k++) begin
         if (re[PA[k]] == re[PB[k]]) cos_w[k]++;
         if (re[PA[k]] == im[PB[k]]) sin_w[k]++;
      end
      prev   = re;
      active = 1'b1;
      if (cnt == bs) begin             // Block complete, counts wait for switch_o
         cos_p = cos_w;
         sin_p = sin_w;
         pend  = 1'b1;
         foreach (cos_w[k]) begin
            cos_w[k] = 0;
            sin_w[k] = 0;
         end
         cnt = 0;
      end else cnt++;
   endtask

   function automatic logic [15:0] expect_word(input logic [4:0] a);
      int p;
      p = a[2:1] + 3 * a[3];
      if (a[4]) return a[3] ? 16'h0 : (a[2:0] == 0) ? 16'(bs) :
                                      (a[2:0] == 1) ? 16'(en) :
                                      (a[2:0] == 2) ? 16'(nblk) : 16'h0;
      if (a[2:1] == 2'd3) return 16'h0; // Words 6 and 7
      return a[0] ? 16'(sin_f[p]) : 16'(cos_f[p]);
   endfunction

   always @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         foreach (cos_w[k]) begin
            cos_w[k] = 0;
            sin_w[k] = 0;
            cos_f[k] = 0;
            sin_f[k] = 0;
         end
         prev    = 4'h0;
         active  = 0;
         en      = 0;
         pend    = 0;
         rd_wait = 0;
         lit_q   = 0;
         bs      = 3;
         cnt     = 0;
         nblk    = 0;
      end else begin
         if (switch_i) begin
            if (pend) begin             // Frozen bank takes the completed block
               cos_f = cos_p;
               sin_f = sin_p;
               pend  = 0;
               nblk++;
            end else begin
               errs++;
               test_errs++;
               $display("Unexpected switch_o pulse at %0t without a completed block", $time);
            end
         end
         if (strobe_i && en) take_sample(antenna_i);
         else if (!en)       active = 0;  // History lost while disabled
         if (bus_rsp_i.ack && rd_wait) begin
            rd_wait = 0;
            if (bus_rsp_i.dat !== expect_word(rd_adr)) begin
               errs++;
               test_errs++;
               $display("Error %0t: read 0x%02h returned 0x%04h, model expects 0x%04h",
                        $time, rd_adr, bus_rsp_i.dat, expect_word(rd_adr));
            end
            if (lit_q && bus_rsp_i.dat !== lit_val_q) begin
               errs++;
               test_errs++;
               $display("Error %0t: read 0x%02h returned 0x%04h, expected 0x%04h",
                        $time, rd_adr, bus_rsp_i.dat, lit_val_q);
            end
         end
         if (bus_req_i.cyc && bus_req_i.stb) begin
            rd_wait   = !bus_req_i.we;
            rd_adr    = bus_req_i.adr;
            lit_q     = lit_en_i && !bus_req_i.we;   // Held until this read's ack
            lit_val_q = lit_val_i;
            if (bus_req_i.we && bus_req_i.adr[4:3] == 2'd2) begin
               if (bus_req_i.adr[2:0] == 3'd0) bs = bus_req_i.dat;
               if (bus_req_i.adr[2:0] == 3'd1) en = bus_req_i.dat[0];
            end
         end

         // ----------------------------------------------------------
         // Per-test lines and closing counts
         // ----------------------------------------------------------
         if (test_i != cur_test) begin
            if (cur_test != 0) begin
               if (test_errs == 0) tests_ok++;
               else tests_bad++;
               $display("Test %0d: %s (%0d errors)", cur_test,
                        test_errs == 0 ? "ok" : "failing", test_errs);
               if (test_i == 0)
                  $display("Tests ok: %0d, tests failing: %0d", tests_ok, tests_bad);
            end
            cur_test  = test_i;
            test_errs = 0;
         end
      end
   end

endmodule

//--- tb_corr.sv
module tb_corr;

   timeunit 1ns;
   timeprecision 100ps;

   typedef enum {OP_WR, OP_RD, OP_RDALL, OP_BURST} op_e;

   typedef struct {
      int          test;
      op_e         op;
      logic [4:0]  adr;
      int          len;            // Burst length
      logic [15:0] dat;            // Write data, literal or fixed sample
      bit          flag;           // Literal check, or random burst
      bit          want_sw;        // Burst must end in switch_o
   } row_t;

   logic               clk_i;
   logic               sw_d;
   logic               strobe_i;
   logic               switch_o;
   logic               lit_en;
   logic [3:0]         antenna_i;
   logic [15:0]        lit_val;
   logic [7:0]         test_id;
   corr_pkg::bus_req_t bus_req;
   corr_pkg::bus_rsp_t bus_rsp;
   int                 mon_err;
   bit                 hung;
   row_t               rows [$];

   corr_top #(.ACCUM_BITS(16)) uut (
      .clk_i (clk_i), .sw_d (sw_d), .bus_req_i (bus_req), .strobe_i (strobe_i),
      .antenna_i (antenna_i), .bus_rsp_o (bus_rsp), .switch_o (switch_o)
   );

   tb_monitor u_mon (
      .clk_i (clk_i), .sw_d (sw_d), .strobe_i (strobe_i), .antenna_i (antenna_i),
      .bus_req_i (bus_req), .bus_rsp_i (bus_rsp), .switch_i (switch_o),
      .test_i (test_id), .lit_en_i (lit_en), .lit_val_i (lit_val), .err_cnt_o (mon_err)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;   // 20 ns period
   end

   task automatic add_row(input int t, op_e op, logic [4:0] a, int n, logic [15:0] d,
                          bit f, bit s);
      row_t r;
      r = '{t, op, a, n, d, f, s};
      rows.push_back(r);
   endtask

   // One access, then wait for ack
   task automatic bus_access(input bit we, logic [4:0] adr, logic [15:0] dat);
      bit got;
      @(posedge clk_i);
      #2 bus_req = '{1'b1, 1'b1, we, adr, dat};
      @(posedge clk_i);
      #2 bus_req = '0;
      got = 0;
      for (int c = 0; c < 50 && !got; c++) begin
         @(posedge clk_i);
         #1 got = bus_rsp.ack;
      end
      if (!got) begin
         $display("Timeout: no bus ack for address 0x%02h within 50 cycles", adr);
         hung = 1;
      end
   endtask

   task automatic send_burst(input int n, bit rnd, logic [3:0] val, bit want_sw);
      bit got;
      for (int i = 0; i < n; i++) begin
         @(posedge clk_i);
         #2 strobe_i = 1'b1;
         antenna_i = rnd ? 4'($urandom()) : val;
      end
      @(posedge clk_i);
      #2 strobe_i = 1'b0;
      got = 0;
      for (int c = 0; c < 50 && want_sw && !got; c++) begin
         @(posedge clk_i);
         #1 got = switch_o;
      end
      if (want_sw && !got) begin
         $display("Timeout: switch_o did not pulse within 50 cycles after a burst");
         hung = 1;
      end
      repeat (4) @(posedge clk_i);    // Pipeline drains
   endtask

   initial begin
      void'($urandom(32'hcbaf86a8));
      sw_d      = 1'b1;
      strobe_i  = 1'b0;
      antenna_i = 4'h0;
      bus_req   = '0;
      lit_en    = 1'b0;
      lit_val   = 16'h0;
      test_id   = 8'd0;
      hung      = 0;
      // Test 1: reset values
      add_row(1, OP_RDALL, 0, 0, 0, 0, 0);
      add_row(1, OP_RD, 5'd16, 0, 16'd3, 1, 0);
      add_row(1, OP_RD, 5'd17, 0, 16'd0, 1, 0);
      add_row(1, OP_RD, 5'd18, 0, 16'd0, 1, 0);
      // Test 2: register access, ignored counter write
      add_row(2, OP_WR, 5'd16, 0, 16'd5, 0, 0);
      add_row(2, OP_RD, 5'd16, 0, 16'd5, 1, 0);
      add_row(2, OP_WR, 5'd17, 0, 16'd1, 0, 0);
      add_row(2, OP_RD, 5'd17, 0, 16'd1, 1, 0);
      add_row(2, OP_WR, 5'd17, 0, 16'd0, 0, 0);
      add_row(2, OP_WR, 5'd16, 0, 16'd7, 0, 0);
      add_row(2, OP_RD, 5'd16, 0, 16'd7, 1, 0);
      add_row(2, OP_WR, 5'd2, 0, 16'habcd, 0, 0);
      add_row(2, OP_RDALL, 0, 0, 0, 0, 0);
      // Test 3: random block of 8
      add_row(3, OP_WR, 5'd17, 0, 16'd1, 0, 0);
      add_row(3, OP_BURST, 0, 8, 0, 1, 1);
      add_row(3, OP_RDALL, 0, 0, 0, 0, 0);
      // Test 4: all antennas equal, cosine 8 on every pair
      add_row(4, OP_BURST, 0, 8, 16'hf, 0, 1);
      for (int w = 0; w < 16; w += 2)
         if (w % 8 < 6) add_row(4, OP_RD, 5'(w), 0, 16'd8, 1, 0);
      add_row(4, OP_RDALL, 0, 0, 0, 0, 0);
      add_row(4, OP_RD, 5'd18, 0, 16'd2, 1, 0);
      // Test 5: strobes while disabled, then history restarts
      add_row(5, OP_WR, 5'd17, 0, 16'd0, 0, 0);
      add_row(5, OP_BURST, 0, 5, 0, 1, 0);
      add_row(5, OP_RDALL, 0, 0, 0, 0, 0);
      add_row(5, OP_RD, 5'd18, 0, 16'd2, 1, 0);
      add_row(5, OP_WR, 5'd17, 0, 16'd1, 0, 0);
      add_row(5, OP_BURST, 0, 8, 0, 1, 1);
      add_row(5, OP_RDALL, 0, 0, 0, 0, 0);
      add_row(5, OP_RD, 5'd18, 0, 16'd3, 1, 0);
      repeat (4) @(posedge clk_i);
      #2 sw_d = 1'b0;

      // ----------------------------------------------------------
      // Apply the table
      // ----------------------------------------------------------
      foreach (rows[i]) begin
         if (hung) break;
         test_id = 8'(rows[i].test);
         lit_en  = 1'b0;
         case (rows[i].op)
            OP_WR:    bus_access(1'b1, rows[i].adr, rows[i].dat);
            OP_RD: begin
               lit_en  = rows[i].flag;
               lit_val = rows[i].dat;
               bus_access(1'b0, rows[i].adr, 16'h0);
            end
            OP_RDALL:
               for (int j = 0; j < 16 && !hung; j++) bus_access(1'b0, 5'(j), 16'h0);
            default:  send_burst(rows[i].len, rows[i].flag, rows[i].dat[3:0], rows[i].want_sw);
         endcase
      end
      repeat (3) @(posedge clk_i);
      #2 test_id = 8'd0;
      repeat (2) @(posedge clk_i);
      if (!hung && mon_err == 0 && uut.u_chk.fail_cnt == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- compile.f
corr_pkg.sv
hilbert_delay.sv
bank_control.sv
correlator_block.sv
visibility_bus.sv
corr_top.sv
corr_checker.sv
tb_monitor.sv
tb_corr.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_corr
FLIST     ?= compile.f
PASS      := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS)'

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
